//--- hdl/display_pkg.sv
// ------------------------------
// shared constants and types for the hex display subsystem
// referred to by scoped names from the RTL and testbench
// ------------------------------
`default_nettype none

package display_pkg;

	localparam int NUM_DIGITS = 4;
	localparam int NUM_SEGMENTS = 7; // a through g
	localparam int SLOT_CYCLES = 4; // clock cycles per segment slot
	localparam int DISPLAY_DATA_WIDTH = NUM_DIGITS * 4;

	localparam int AXI_ADDR_WIDTH = 4;
	localparam int AXI_DATA_WIDTH = 32;
	localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

	localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_DATA = 4'h0;
	localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_CONTROL = 4'h4;
	localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_FRAMES = 4'h8; // read only
	localparam int CONTROL_ENABLE_BIT = 0;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef logic [NUM_SEGMENTS-1:0] segment_pattern_t; // active low, bit 6 is a, bit 0 is g
	typedef logic [$clog2(NUM_DIGITS)-1:0] digit_index_t;
	typedef logic [$clog2(NUM_SEGMENTS)-1:0] segment_index_t;
	typedef logic [$clog2(SLOT_CYCLES)-1:0] slot_index_t;

	localparam digit_index_t LAST_DIGIT = digit_index_t'(NUM_DIGITS - 1);
	localparam segment_index_t LAST_SEGMENT = segment_index_t'(NUM_SEGMENTS - 1);
	localparam slot_index_t LAST_SLOT = slot_index_t'(SLOT_CYCLES - 1);

	// hex glyphs, indexed by nybble value
	localparam segment_pattern_t HEX_SEGMENTS [16] = '{
		7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,
		7'b1001100, 7'b0100100, 7'b0100000, 7'b0001111,
		7'b0000000, 7'b0000100, 7'b0001000, 7'b1100000,
		7'b1110010, 7'b1000010, 7'b0110000, 7'b0111000
	};

endpackage

`default_nettype wire

//--- hdl/scan_bus_if.sv
// ------------------------------
// scan position and strobes, from scan_control to the datapath
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

interface scan_bus_if;

	logic frame_start; // first slot of digit 0, only while enabled
	logic slot_start; // one cycle per segment slot
	display_pkg::digit_index_t digit;
	display_pkg::segment_index_t segment;
	logic active; // scanning enabled for this slot

	modport control (
		output frame_start, slot_start, digit, segment, active
	);

	modport buffer (
		input frame_start, digit
	);

	modport strobe (
		input frame_start, slot_start, digit, segment, active
	);

endinterface

`default_nettype wire

//--- hdl/axil_display_regs.sv
// ------------------------------
// AXI4-Lite slave with data, control and frame counter registers
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module axil_display_regs (
	input  logic clock,
	input  logic reset,
	input  logic [display_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [display_pkg::AXI_DATA_WIDTH-1:0] wdata,
	input  logic [display_pkg::AXI_STRB_WIDTH-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [display_pkg::AXI_ADDR_WIDTH-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [display_pkg::AXI_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic [display_pkg::DISPLAY_DATA_WIDTH-1:0] display_data,
	output logic enable,
	input  logic frame_done
);
	logic aw_held, w_held; // one side of a write arrived first
	logic [display_pkg::AXI_ADDR_WIDTH-1:0] aw_addr_q;
	logic [display_pkg::AXI_DATA_WIDTH-1:0] w_data_q;
	logic [display_pkg::AXI_STRB_WIDTH-1:0] w_strb_q;
	logic aw_fire, w_fire, ar_fire, write_go, write_ok;
	logic [display_pkg::AXI_ADDR_WIDTH-1:0] wr_addr;
	logic [display_pkg::AXI_DATA_WIDTH-1:0] wr_data;
	logic [display_pkg::AXI_STRB_WIDTH-1:0] wr_strb;
	logic [display_pkg::DISPLAY_DATA_WIDTH-1:0] frames;
	logic [display_pkg::AXI_DATA_WIDTH-1:0] rd_word;
	logic rd_ok;

	assign awready = !aw_held && !bvalid;
	assign wready = !w_held && !bvalid;
	assign arready = !rvalid;
	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;
	assign ar_fire = arvalid && arready;
	assign write_go = (aw_held || aw_fire) && (w_held || w_fire);

	// take whichever copy is current, held or on the bus
	assign wr_addr = aw_held ? aw_addr_q : awaddr;
	assign wr_data = w_held ? w_data_q : wdata;
	assign wr_strb = w_held ? w_strb_q : wstrb;
	assign write_ok = (wr_addr == display_pkg::ADDR_DATA) || (wr_addr == display_pkg::ADDR_CONTROL);

	always_comb begin
		rd_word = '0;
		rd_ok = 1'b1;
		case (araddr)
			display_pkg::ADDR_DATA: rd_word[display_pkg::DISPLAY_DATA_WIDTH-1:0] = display_data;
			display_pkg::ADDR_CONTROL: rd_word[display_pkg::CONTROL_ENABLE_BIT] = enable;
			display_pkg::ADDR_FRAMES: rd_word[display_pkg::DISPLAY_DATA_WIDTH-1:0] = frames;
			default: rd_ok = 1'b0; // unmapped, zero data
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			display_data <= '0;
			enable <= 1'b0;
			frames <= '0;
		end else begin
			aw_held <= !write_go && (aw_held || aw_fire);
			w_held <= !write_go && (w_held || w_fire);
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end else if (write_go) begin
				bvalid <= 1'b1;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end else if (ar_fire) begin
				rvalid <= 1'b1;
			end
			if (write_go && wr_addr == display_pkg::ADDR_DATA) begin
				for (int b = 0; b < display_pkg::DISPLAY_DATA_WIDTH / 8; b++) begin
					if (wr_strb[b]) begin
						display_data[8*b +: 8] <= wr_data[8*b +: 8];
					end
				end
			end
			if (write_go && wr_addr == display_pkg::ADDR_CONTROL && wr_strb[0]) begin
				enable <= wr_data[display_pkg::CONTROL_ENABLE_BIT];
			end
			if (frame_done) begin
				frames <= frames + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire) begin
			aw_addr_q <= awaddr;
		end
		if (w_fire) begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
		if (write_go) begin
			bresp <= write_ok ? display_pkg::RESP_OKAY : display_pkg::RESP_SLVERR;
		end
		if (ar_fire) begin
			rdata <= rd_word; // frame count is a snapshot at acceptance
			rresp <= rd_ok ? display_pkg::RESP_OKAY : display_pkg::RESP_SLVERR;
		end
	end

	bresp_held : assert property (@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));
	rresp_held : assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

//--- hdl/scan_control.sv
// ------------------------------
// slot divider and segment, digit and frame sequencer
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module scan_control (
	input  logic clock,
	input  logic reset,
	input  logic enable,
	scan_bus_if.control bus,
	output logic frame_done
);
	display_pkg::slot_index_t slot_count;
	display_pkg::digit_index_t digit;
	display_pkg::segment_index_t segment;
	logic running; // active state of the previous cycle
	logic slot_start, slot_last, at_origin, active;

	assign slot_start = slot_count == '0;
	assign slot_last = slot_count == display_pkg::LAST_SLOT;
	assign at_origin = (digit == '0) && (segment == '0);

	// enable is only looked at on the first slot of a frame, so a clear
	// lets the running frame finish
	assign active = (slot_start && at_origin) ? enable : running;

	assign bus.frame_start = slot_start && at_origin && enable;
	assign bus.slot_start = slot_start;
	assign bus.digit = digit;
	assign bus.segment = segment;
	assign bus.active = active;

	assign frame_done = active && slot_last && (digit == display_pkg::LAST_DIGIT)
		&& (segment == display_pkg::LAST_SEGMENT);

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_count <= '0;
			digit <= '0;
			segment <= '0;
			running <= 1'b0;
		end else begin
			running <= active;
			slot_count <= slot_last ? '0 : slot_count + 1'b1; // free runs, also when blanked
			if (active && slot_last) begin
				if (segment == display_pkg::LAST_SEGMENT) begin
					segment <= '0;
					digit <= (digit == display_pkg::LAST_DIGIT) ? '0 : digit + 1'b1;
				end else begin
					segment <= segment + 1'b1;
				end
			end
		end
	end

	done_wraps_to_origin : assert property (@(posedge clock) disable iff (reset)
		frame_done |=> bus.slot_start && bus.digit == '0 && bus.segment == '0);

endmodule

`default_nettype wire

//--- hdl/pattern_buffer.sv
// ------------------------------
// shadow copy of the display word, taken at frame start,
// and hex decode of the digit under scan
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module pattern_buffer (
	input  logic clock,
	input  logic reset,
	input  logic [display_pkg::DISPLAY_DATA_WIDTH-1:0] display_data,
	scan_bus_if.buffer bus,
	output display_pkg::segment_pattern_t pattern
);
	logic [3:0] shadow [display_pkg::NUM_DIGITS];
	logic [3:0] nybble;

	// whole word is taken at once, so a write mid frame waits for the next one
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < display_pkg::NUM_DIGITS; i++) begin
				shadow[i] <= '0;
			end
		end else if (bus.frame_start) begin
			for (int i = 0; i < display_pkg::NUM_DIGITS; i++) begin
				shadow[i] <= display_data[4*i +: 4];
			end
		end
	end

	// on the frame start cycle the shadow is not loaded yet,
	// so the new nybble is taken straight from the register
	always_comb begin
		if (bus.frame_start) begin
			nybble = display_data[{bus.digit, 2'b00} +: 4];
		end else begin
			nybble = shadow[bus.digit];
		end
		pattern = display_pkg::HEX_SEGMENTS[nybble];
	end

endmodule

`default_nettype wire

//--- hdl/segment_strobe.sv
// ------------------------------
// registered anode, cathode and sync drivers
// one digit and one segment lit at a time
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module segment_strobe (
	input  logic clock,
	input  logic reset,
	scan_bus_if.strobe bus,
	input  display_pkg::segment_pattern_t pattern,
	output logic [display_pkg::NUM_DIGITS-1:0] anode,
	output display_pkg::segment_pattern_t cathode,
	output logic sync
);
	logic [display_pkg::NUM_SEGMENTS-1:0] token; // one-hot segment select
	logic [display_pkg::NUM_SEGMENTS-1:0] select;
	logic [display_pkg::NUM_DIGITS-1:0] anode_next;
	display_pkg::segment_pattern_t cathode_next;

	always_comb begin
		if (!bus.slot_start) begin
			select = token;
		end else if (bus.segment == '0) begin
			select = {{(display_pkg::NUM_SEGMENTS-1){1'b0}}, 1'b1}; // back to segment a
		end else begin
			select = {token[display_pkg::NUM_SEGMENTS-2:0], token[display_pkg::NUM_SEGMENTS-1]};
		end
		for (int i = 0; i < display_pkg::NUM_DIGITS; i++) begin
			anode_next[i] = bus.active && (bus.digit == i);
		end
		// cathode keeps the pattern layout, select bit s is segment s counting from a
		for (int c = 0; c < display_pkg::NUM_SEGMENTS; c++) begin
			if (bus.active && select[display_pkg::NUM_SEGMENTS-1-c]) begin
				cathode_next[c] = pattern[c];
			end else begin
				cathode_next[c] = 1'b1; // off
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			token <= {{(display_pkg::NUM_SEGMENTS-1){1'b0}}, 1'b1};
			anode <= '0;
			cathode <= '1;
			sync <= 1'b0;
		end else begin
			token <= select;
			anode <= anode_next;
			cathode <= cathode_next;
			sync <= bus.frame_start; // one cycle per frame
		end
	end

	anode_onehot0 : assert property (@(posedge clock) disable iff (reset)
		$onehot0(anode));

endmodule

`default_nettype wire

//--- hdl/display_top.sv
// ------------------------------
// four digit hex display with AXI4-Lite register access
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module display_top (
	input  logic clock,
	input  logic reset,
	input  logic [display_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [display_pkg::AXI_DATA_WIDTH-1:0] wdata,
	input  logic [display_pkg::AXI_STRB_WIDTH-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [display_pkg::AXI_ADDR_WIDTH-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [display_pkg::AXI_DATA_WIDTH-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic [display_pkg::NUM_DIGITS-1:0] anode,
	output display_pkg::segment_pattern_t cathode,
	output logic sync
);
	logic [display_pkg::DISPLAY_DATA_WIDTH-1:0] display_data;
	logic enable;
	logic frame_done;
	display_pkg::segment_pattern_t pattern;

	scan_bus_if bus ();

	axil_display_regs regs (
		.clock, .reset,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.display_data, .enable, .frame_done
	);

	scan_control control (.clock, .reset, .enable, .bus(bus.control), .frame_done);

	pattern_buffer buffer (.clock, .reset, .display_data, .bus(bus.buffer), .pattern);

	segment_strobe strobe (
		.clock, .reset,
		.bus(bus.strobe),
		.pattern,
		.anode, .cathode, .sync
	);

endmodule

`default_nettype wire

//--- tests/display_checker.sv
// ------------------------------
// watches the display DUT, models its registers and the scan,
// and reports every mismatch on the AXI and display ports
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module display_checker (
	input logic clock,
	input logic reset,
	input logic [3:0] awaddr,
	input logic awvalid, awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid, wready,
	input logic [1:0] bresp,
	input logic bvalid, bready,
	input logic [3:0] araddr,
	input logic arvalid, arready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid, rready,
	input logic [3:0] anode,
	input logic [6:0] cathode,
	input logic sync
);
	localparam int SLOT_CYCLES = display_pkg::SLOT_CYCLES;
	localparam int DIGIT_CYCLES = SLOT_CYCLES * display_pkg::NUM_SEGMENTS;
	localparam int FRAME_CYCLES = DIGIT_CYCLES * display_pkg::NUM_DIGITS;

	logic [6:0] glyph [16]; // active low, segment a in bit 6
	int errors;
	logic [15:0] data_model, data_prev, frame_value, frames_model;
	logic enable_model, enable_prev;
	logic aw_seen, w_seen;
	logic [3:0] aw_addr;
	logic [31:0] w_data;
	logic [3:0] w_strb;
	logic [1:0] bresp_q [$];
	logic [33:0] read_q [$]; // {rresp, rdata}
	int phase; // output cycle within the frame, -1 while blank
	int completion; // cycles until the running frame counts as done
	int idle_enabled; // enabled cycles seen while blank

	initial begin
		errors = 0;
		glyph = '{7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,
			7'b1001100, 7'b0100100, 7'b0100000, 7'b0001111,
			7'b0000000, 7'b0000100, 7'b0001000, 7'b1100000,
			7'b1110010, 7'b1000010, 7'b0110000, 7'b0111000};
	end

	task automatic mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	task automatic failure(input string what);
		errors++;
		$display("** Error at %0t: %s", $time, what);
	endtask

	function automatic logic [33:0] read_value(input logic [3:0] addr);
		case (addr)
			display_pkg::ADDR_DATA: return {2'b00, 16'h0, data_model};
			display_pkg::ADDR_CONTROL: return {2'b00, 31'h0, enable_model};
			display_pkg::ADDR_FRAMES: return {2'b00, 16'h0, frames_model};
			default: return {2'b10, 32'h0}; // SLVERR
		endcase
	endfunction

	always @(posedge clock) begin
		int digit;
		int segment;
		logic [3:0] anode_exp;
		logic [6:0] cathode_exp;
		logic awready_exp, wready_exp, arready_exp;
		if (reset) begin
			data_model = '0;
			data_prev = '0;
			frame_value = '0;
			frames_model = '0;
			enable_model = 1'b0;
			enable_prev = 1'b0;
			aw_seen = 1'b0;
			w_seen = 1'b0;
			bresp_q.delete();
			read_q.delete();
			phase = -1;
			completion = 0;
			idle_enabled = 0;
		end else begin
			// ready follows from what is still outstanding
			awready_exp = !aw_seen && bresp_q.size() == 0;
			wready_exp = !w_seen && bresp_q.size() == 0;
			arready_exp = read_q.size() == 0;
			if (awready !== awready_exp) mismatch("awready", awready_exp, awready);
			if (wready !== wready_exp) mismatch("wready", wready_exp, wready);
			if (arready !== arready_exp) mismatch("arready", arready_exp, arready);
			// held responses are compared on every cycle until taken
			if (bvalid !== (bresp_q.size() != 0)) begin
				mismatch("bvalid", bresp_q.size() != 0, bvalid);
			end else if (bvalid) begin
				if (bresp !== bresp_q[0]) mismatch("bresp", bresp_q[0], bresp);
				if (bready) void'(bresp_q.pop_front());
			end
			if (rvalid !== (read_q.size() != 0)) begin
				mismatch("rvalid", read_q.size() != 0, rvalid);
			end else if (rvalid) begin
				if (rdata !== read_q[0][31:0]) mismatch("rdata", read_q[0][31:0], rdata);
				if (rresp !== read_q[0][33:32]) mismatch("rresp", read_q[0][33:32], rresp);
				if (rready) void'(read_q.pop_front());
			end
			if (arvalid && arready) read_q.push_back(read_value(araddr));
			if (completion > 0) begin
				completion--;
				if (completion == 0) frames_model++;
			end
			if (phase >= 0 && phase < FRAME_CYCLES - 1) begin
				phase++;
				if (sync) failure("sync pulse in the middle of a frame");
			end else begin
				if (sync && !enable_prev) failure("sync while the display is disabled");
				if (!sync && enable_prev && (phase == FRAME_CYCLES - 1
						|| idle_enabled >= SLOT_CYCLES - 1)) begin
					failure("no sync although the display is enabled");
				end
				if (sync) begin
					phase = 0;
					frame_value = data_prev; // as it stood at frame start
					completion = FRAME_CYCLES - 2;
					idle_enabled = 0;
				end else begin
					phase = -1;
					idle_enabled = enable_prev ? idle_enabled + 1 : 0;
				end
			end
			anode_exp = '0;
			cathode_exp = '1;
			if (phase >= 0) begin
				digit = phase / DIGIT_CYCLES;
				segment = (phase % DIGIT_CYCLES) / SLOT_CYCLES;
				anode_exp[digit] = 1'b1;
				// segment a drives the top cathode bit, like the glyph
				cathode_exp[6 - segment] = glyph[frame_value[4*digit +: 4]][6 - segment];
			end
			if (anode !== anode_exp) mismatch("anode", anode_exp, anode);
			if (cathode !== cathode_exp) mismatch("cathode", cathode_exp, cathode);
			// writes land at the end of this cycle
			data_prev = data_model;
			enable_prev = enable_model;
			if (awvalid && awready) begin
				aw_seen = 1'b1;
				aw_addr = awaddr;
			end
			if (wvalid && wready) begin
				w_seen = 1'b1;
				w_data = wdata;
				w_strb = wstrb;
			end
			if (aw_seen && w_seen) begin
				aw_seen = 1'b0;
				w_seen = 1'b0;
				if (aw_addr == display_pkg::ADDR_DATA) begin
					if (w_strb[0]) data_model[7:0] = w_data[7:0];
					if (w_strb[1]) data_model[15:8] = w_data[15:8];
					bresp_q.push_back(2'b00);
				end else if (aw_addr == display_pkg::ADDR_CONTROL) begin
					if (w_strb[0]) enable_model = w_data[0];
					bresp_q.push_back(2'b00);
				end else begin
					bresp_q.push_back(2'b10); // read only or unmapped
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_display_top.sv
// ------------------------------
// testbench for the hex display, random AXI4-Lite traffic
// from a fixed seed, checked by display_checker
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_display_top;

	localparam int CLOCK_PERIOD = 8;
	localparam int FRAME_CYCLES = display_pkg::NUM_DIGITS * display_pkg::NUM_SEGMENTS
		* display_pkg::SLOT_CYCLES;
	localparam int PLANNED_FRAMES = 40;
	localparam int WATCHDOG_CYCLES = PLANNED_FRAMES * FRAME_CYCLES + 2000;

	logic clock, reset;
	logic [3:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	logic [3:0] anode;
	display_pkg::segment_pattern_t cathode;
	logic sync;
	int tb_errors, test_base, tests_run, tests_failed;

	display_top u_dut (.*);
	display_checker u_checker (.*);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int order; // 0 together, 1 address first, 2 data first
		int limit;
		bit aw_done;
		bit w_done;
		order = $urandom_range(2);
		aw_done = 1'b0;
		w_done = 1'b0;
		limit = 0;
		@(posedge clock);
		#1;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = (order != 2);
		wvalid = (order != 1);
		while (!(aw_done && w_done) && limit < 50) begin
			@(posedge clock);
			aw_done |= awvalid && awready;
			w_done |= wvalid && wready;
			limit++;
			#1;
			awvalid = !aw_done && (w_done || order != 2);
			wvalid = !w_done && (aw_done || order != 1);
		end
		if (!(aw_done && w_done)) begin
			tb_errors++;
			$display("write to address %h was never accepted", addr);
		end
		repeat ($urandom_range(3)) @(posedge clock); // stall bready now and then
		#1;
		bready = 1'b1;
		limit = 0;
		do begin
			@(posedge clock);
			limit++;
		end while (!bvalid && limit < 50);
		if (!bvalid) begin
			tb_errors++;
			$display("write to address %h got no response", addr);
		end
		#1;
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr);
		int limit;
		limit = 0;
		@(posedge clock);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		do begin
			@(posedge clock);
			limit++;
		end while (!arready && limit < 50);
		if (!arready) begin
			tb_errors++;
			$display("read of address %h was never accepted", addr);
		end
		#1;
		arvalid = 1'b0;
		repeat ($urandom_range(3)) @(posedge clock);
		#1;
		rready = 1'b1;
		limit = 0;
		do begin
			@(posedge clock);
			limit++;
		end while (!rvalid && limit < 50);
		if (!rvalid) begin
			tb_errors++;
			$display("read of address %h got no response", addr);
		end
		#1;
		rready = 1'b0;
	endtask

	task automatic finish_test(input string name);
		int total;
		total = tb_errors + u_checker.errors;
		tests_run++;
		if (total == test_base) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests_run, name, total - test_base);
		end
		test_base = total;
	endtask

	initial begin
		int total;
		void'($urandom(30885));
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		tb_errors = 0;
		test_base = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		repeat (24) begin
			if ($urandom_range(1)) begin
				write_reg($urandom_range(1) ? display_pkg::ADDR_CONTROL : display_pkg::ADDR_DATA,
					$urandom, 4'($urandom_range(15)));
			end else begin
				read_reg(4'(4 * $urandom_range(2)));
			end
		end
		finish_test("register access");

		repeat (24) begin
			if ($urandom_range(1)) begin
				write_reg(4'($urandom_range(15)), $urandom, 4'($urandom_range(15)));
			end else begin
				read_reg(4'($urandom_range(15)));
			end
		end
		finish_test("error responses");

		write_reg(display_pkg::ADDR_DATA, $urandom, 4'hf);
		write_reg(display_pkg::ADDR_CONTROL, 32'h1, 4'hf);
		repeat (4) @(posedge sync);
		read_reg(display_pkg::ADDR_FRAMES);
		read_reg(display_pkg::ADDR_DATA);
		finish_test("scan order and segments");

		// data writes land at random points inside a frame
		repeat (8) begin
			@(posedge sync);
			repeat ($urandom_range(90)) @(posedge clock);
			write_reg(display_pkg::ADDR_DATA, $urandom, 4'($urandom_range(15)));
		end
		repeat (2) @(posedge sync);
		finish_test("frame consistency");

		@(posedge sync);
		repeat ($urandom_range(80)) @(posedge clock);
		write_reg(display_pkg::ADDR_CONTROL, 32'h0, 4'hf);
		repeat (3 * FRAME_CYCLES) @(posedge clock); // blank for several frame times
		read_reg(display_pkg::ADDR_CONTROL);
		write_reg(display_pkg::ADDR_CONTROL, 32'h1, 4'hf);
		repeat (2) @(posedge sync);
		read_reg(display_pkg::ADDR_FRAMES);
		finish_test("blanking");

		total = tb_errors + u_checker.errors;
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total);
		if (total == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hdl/display_pkg.sv
hdl/scan_bus_if.sv
hdl/axil_display_regs.sv
hdl/scan_control.sv
hdl/pattern_buffer.sv
hdl/segment_strobe.sv
hdl/display_top.sv
tests/display_checker.sv
tests/tb_display_top.sv
